//--- common/pf_pkg.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Read prefetcher shared sizes and types
// Bus widths, queue geometry and the prefetch ID
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`default_nettype none

package pf_pkg;

    // AXI field widths
    localparam int ADDR_BITS = 32;
    localparam int ID_BITS   = 4;
    localparam int LEN_BITS  = 8;
    localparam int DATA_BITS = 64;           // One beat carries one block

    // Stream geometry
    localparam int BLOCK_BYTES = 8;          // Address step between blocks
    localparam int QUEUE_LOG   = 2;
    localparam int QUEUE_DEPTH = 1 << QUEUE_LOG;

    // Reserved ID for prefetch reads, never issued by the master
    localparam logic [ID_BITS-1:0] PF_ID = '1;

    typedef logic [ADDR_BITS-1:0] addr_t;
    typedef logic [ID_BITS-1:0]   id_t;
    typedef logic [LEN_BITS-1:0]  len_t;
    typedef logic [DATA_BITS-1:0] data_t;

    // Occupancy count, one bit wider so a full queue fits
    typedef logic [QUEUE_LOG:0] cnt_t;

endpackage

`default_nettype wire

//--- source/req_steer.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Request steering for the read prefetcher
// Splits AR traffic between the stream and memory
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`default_nettype none

module req_steer (
    input  wire                clk,
    input  wire                rst_n,
    input  wire                en,
    input  wire pf_pkg::addr_t bar,
    input  wire pf_pkg::addr_t limit,
    input  wire                s_ar_valid,
    output logic               s_ar_ready,
    input  wire pf_pkg::addr_t s_ar_addr,
    input  wire pf_pkg::id_t   s_ar_id,
    input  wire pf_pkg::len_t  s_ar_len,
    output logic               m_ar_valid,
    input  wire                m_ar_ready,
    output pf_pkg::addr_t      m_ar_addr,
    output pf_pkg::id_t        m_ar_id,
    output pf_pkg::len_t       m_ar_len,
    output logic               ctrl_req_valid,
    input  wire                ctrl_req_ready,
    input  wire                ctrl_ar_valid,
    output logic               ctrl_ar_ready,
    input  wire pf_pkg::addr_t ctrl_ar_addr,
    input  wire pf_pkg::id_t   ctrl_ar_id,
    input  wire pf_pkg::len_t  ctrl_ar_len,
    input  wire                s_aw_valid,
    output logic               s_aw_ready,
    input  wire pf_pkg::addr_t s_aw_addr,
    input  wire pf_pkg::id_t   s_aw_id,
    output logic               m_aw_valid,
    input  wire                m_aw_ready,
    output logic               flush
);
    import pf_pkg::*;

    logic in_window;
    logic aw_in_window;

    always_comb begin
        // Only single beat reads inside bar..limit belong to the stream
        in_window = en && (s_ar_len == '0) && (s_ar_addr >= bar) && (s_ar_addr <= limit);
        aw_in_window = en && (s_aw_addr >= bar) && (s_aw_addr <= limit);

        ctrl_req_valid = s_ar_valid && in_window;

        if (ctrl_ar_valid) begin          // Controller owns the master AR
            m_ar_valid    = 1'b1;
            m_ar_addr     = ctrl_ar_addr;
            m_ar_id       = ctrl_ar_id;
            m_ar_len      = ctrl_ar_len;
            ctrl_ar_ready = m_ar_ready;
        end else begin
            m_ar_valid    = s_ar_valid && !in_window;
            m_ar_addr     = s_ar_addr;
            m_ar_id       = s_ar_id;
            m_ar_len      = s_ar_len;
            ctrl_ar_ready = 1'b0;
        end

        // Bypass reads wait while the controller uses the channel
        s_ar_ready = in_window ? ctrl_req_ready : (!ctrl_ar_valid && m_ar_ready);

        m_aw_valid = s_aw_valid;
        s_aw_ready = m_aw_ready;
        flush      = s_aw_valid && m_aw_ready && aw_in_window;
    end

    // A waiting read keeps the path it was first given
    a_path_stable: assert property (@(posedge clk) disable iff (!rst_n)
        s_ar_valid && !s_ar_ready |=> ctrl_req_valid == $past(ctrl_req_valid))
        else $error("read request changed path before acceptance");

    // The prefetch ID must stay private to the controller
    a_ar_id_free: assert property (@(posedge clk) disable iff (!rst_n)
        s_ar_valid |-> s_ar_id != PF_ID)
        else $error("master read uses the prefetch ID");

    a_aw_id_free: assert property (@(posedge clk) disable iff (!rst_n)
        s_aw_valid |-> s_aw_id != PF_ID)
        else $error("master write uses the prefetch ID");

endmodule

`default_nettype wire

//--- prefetch/stream_ctrl.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Sequential stream controller
// Hit/miss decision, demand reads and prefetch issue
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`default_nettype none

module stream_ctrl (
    input  wire                clk,
    input  wire                rst_n,
    input  wire pf_pkg::addr_t limit,
    input  wire                ctrl_req_valid,
    output logic               ctrl_req_ready,
    input  wire pf_pkg::addr_t s_ar_addr,
    input  wire pf_pkg::id_t   s_ar_id,
    input  wire pf_pkg::len_t  s_ar_len,
    output logic               ctrl_ar_valid,
    input  wire                ctrl_ar_ready,
    output pf_pkg::addr_t      ctrl_ar_addr,
    output pf_pkg::id_t        ctrl_ar_id,
    output pf_pkg::len_t       ctrl_ar_len,
    output logic               hit_valid,
    input  wire                hit_ready,
    output pf_pkg::data_t      hit_data,
    output pf_pkg::id_t        hit_id,
    input  wire                flush,
    output logic               push,
    output pf_pkg::addr_t      push_addr,
    output logic               pop,
    output logic               clear,
    input  wire                head_valid,
    input  wire                head_filled,
    input  wire pf_pkg::addr_t head_tag,
    input  wire pf_pkg::data_t head_data,
    input  wire pf_pkg::addr_t tail_next,
    input  wire pf_pkg::cnt_t  count
);
    import pf_pkg::*;

    typedef enum logic [2:0] {IDLE, WAIT_FILL, RESPOND, DEMAND, PREFETCH} state_t;

    state_t state;
    state_t state_nxt;

    addr_t req_addr;
    id_t   req_id;
    len_t  req_len;
    addr_t next_addr;                    // Next block of the stream
    addr_t pf_addr;
    addr_t dem_addr;
    id_t   dem_id;
    len_t  dem_len;
    logic  accept;
    logic  is_hit;
    logic  can_issue;
    logic  ar_done;
    logic  start_demand;
    logic  start_pf;
    logic  start_hit;

    always_comb begin
        ctrl_req_ready = (state == IDLE);
        hit_valid      = (state == RESPOND);
        hit_id         = req_id;
        accept         = ctrl_req_valid && ctrl_req_ready;
        is_hit         = head_valid && (head_tag == s_ar_addr);
        ar_done        = ctrl_ar_valid && ctrl_ar_ready;

        // Empty queue restarts from the stream pointer
        pf_addr   = (count == '0) ? next_addr : tail_next;
        can_issue = (pf_addr <= limit) && (count < cnt_t'(QUEUE_DEPTH));

        // A flushed wait turns into a demand read from the latched request
        dem_addr = (state == IDLE) ? s_ar_addr : req_addr;
        dem_id   = (state == IDLE) ? s_ar_id : req_id;
        dem_len  = (state == IDLE) ? s_ar_len : req_len;

        start_demand = (accept && !is_hit) || (state == WAIT_FILL && flush);
        start_pf     = (state == PREFETCH) && !ctrl_ar_valid && !flush && can_issue;
        start_hit    = (accept && is_hit && head_filled) ||
                       (state == WAIT_FILL && !flush && head_filled);

        push      = (state == PREFETCH) && ar_done;
        push_addr = ctrl_ar_addr;
        pop       = hit_valid && hit_ready && head_valid;
        clear     = accept && !is_hit;   // Miss restarts the stream
    end

    always_comb begin
        state_nxt = state;
        case (state)
            IDLE: begin
                if (accept) begin
                    if (!is_hit)
                        state_nxt = DEMAND;
                    else
                        state_nxt = head_filled ? RESPOND : WAIT_FILL;
                end
            end
            WAIT_FILL: begin
                if (flush)
                    state_nxt = DEMAND;
                else if (head_filled)
                    state_nxt = RESPOND;
            end
            RESPOND: begin
                // Each served hit tops the queue up by one block
                if (hit_ready)
                    state_nxt = head_valid ? PREFETCH : IDLE;
            end
            DEMAND: begin
                if (ctrl_ar_ready)
                    state_nxt = PREFETCH;
            end
            PREFETCH: begin
                if (ar_done ? flush : (!ctrl_ar_valid && (flush || !can_issue)))
                    state_nxt = IDLE;
            end
            default: state_nxt = IDLE;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state         <= IDLE;
            ctrl_ar_valid <= 1'b0;
        end else begin
            state <= state_nxt;
            if (start_demand || start_pf)
                ctrl_ar_valid <= 1'b1;
            else if (ar_done)
                ctrl_ar_valid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            req_addr <= s_ar_addr;
            req_id   <= s_ar_id;
            req_len  <= s_ar_len;
        end
        if (start_demand) begin
            ctrl_ar_addr <= dem_addr;
            ctrl_ar_id   <= dem_id;
            ctrl_ar_len  <= dem_len;
            next_addr    <= dem_addr + addr_t'(BLOCK_BYTES);
        end else if (start_pf) begin
            ctrl_ar_addr <= pf_addr;
            ctrl_ar_id   <= PF_ID;
            ctrl_ar_len  <= '0;
            next_addr    <= pf_addr + addr_t'(BLOCK_BYTES);
        end
        if (start_hit)
            hit_data <= head_data;       // Held stable through back-pressure
    end

endmodule

`default_nettype wire

//--- prefetch/block_queue.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Prefetch block queue
// Circular tag/data store filled in issue order
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`default_nettype none

module block_queue (
    input  wire                clk,
    input  wire                rst_n,
    input  wire                push,
    input  wire pf_pkg::addr_t push_addr,
    input  wire                pop,
    input  wire                clear,
    input  wire                flush,
    input  wire                fill_valid,
    input  wire pf_pkg::data_t fill_data,
    output logic               head_valid,
    output logic               head_filled,
    output pf_pkg::addr_t      head_tag,
    output pf_pkg::data_t      head_data,
    output pf_pkg::addr_t      tail_next,
    output pf_pkg::cnt_t       count
);
    import pf_pkg::*;

    typedef logic [QUEUE_LOG-1:0] ptr_t;
    typedef logic [QUEUE_LOG+2:0] disc_t;    // Room for several flushes in flight

    addr_t tag_mem [QUEUE_DEPTH];
    data_t data_mem [QUEUE_DEPTH];
    logic [QUEUE_DEPTH-1:0] filled;

    ptr_t  head;
    ptr_t  tail;
    ptr_t  fill_ptr;                         // Oldest slot still waiting for data
    cnt_t  pending;
    disc_t discard;
    logic  empty_all;
    logic  take;

    always_comb begin
        empty_all   = clear || flush;
        take        = fill_valid && (discard == '0);
        head_valid  = (count != '0);
        head_filled = head_valid && filled[head];
        head_tag    = tag_mem[head];
        head_data   = data_mem[head];
        tail_next   = tag_mem[tail - 1'b1] + addr_t'(BLOCK_BYTES);
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            head     <= '0;
            tail     <= '0;
            fill_ptr <= '0;
            count    <= '0;
            pending  <= '0;
            discard  <= '0;
            filled   <= '0;
        end else if (empty_all) begin
            head     <= '0;
            tail     <= '0;
            fill_ptr <= '0;
            count    <= '0;
            pending  <= '0;
            // Every read still in flight now returns stale data
            discard  <= discard + disc_t'(pending) + disc_t'(push) - disc_t'(fill_valid);
        end else begin
            if (push) begin
                tail         <= tail + 1'b1;
                filled[tail] <= 1'b0;
            end
            if (pop)
                head <= head + 1'b1;
            if (take) begin
                filled[fill_ptr] <= 1'b1;
                fill_ptr         <= fill_ptr + 1'b1;
            end else if (fill_valid) begin
                discard <= discard - 1'b1;
            end
            count   <= count + cnt_t'(push) - cnt_t'(pop);
            pending <= pending + cnt_t'(push) - cnt_t'(take);
        end
    end

    always_ff @(posedge clk) begin
        if (push)
            tag_mem[tail] <= push_addr;
        if (take)
            data_mem[fill_ptr] <= fill_data;
    end

    a_no_overflow: assert property (@(posedge clk) disable iff (!rst_n)
        push |-> count != cnt_t'(QUEUE_DEPTH))
        else $error("prefetch pushed into a full queue");

    a_no_underflow: assert property (@(posedge clk) disable iff (!rst_n)
        pop |-> head_valid)
        else $error("hit popped an empty queue");

    // Every PF_ID beat answers a pending slot or a discarded read
    a_fill_expected: assert property (@(posedge clk) disable iff (!rst_n)
        fill_valid |-> (pending != '0) || (discard != '0))
        else $error("prefetch fill with nothing outstanding");

endmodule

`default_nettype wire

//--- source/resp_steer.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Response steering for the read prefetcher
// Sends fills to the queue, merges hits onto s_r
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`default_nettype none

module resp_steer (
    input  wire                clk,
    input  wire                rst_n,
    input  wire                m_r_valid,
    output logic               m_r_ready,
    input  wire pf_pkg::data_t m_r_data,
    input  wire pf_pkg::id_t   m_r_id,
    input  wire                m_r_last,
    output logic               s_r_valid,
    input  wire                s_r_ready,
    output pf_pkg::data_t      s_r_data,
    output pf_pkg::id_t        s_r_id,
    output logic               s_r_last,
    output logic               fill_valid,
    output pf_pkg::data_t      fill_data,
    input  wire                hit_valid,
    output logic               hit_ready,
    input  wire pf_pkg::data_t hit_data,
    input  wire pf_pkg::id_t   hit_id
);
    import pf_pkg::*;

    logic pf_beat;

    always_comb begin
        pf_beat    = m_r_id == PF_ID;
        fill_valid = m_r_valid && pf_beat;   // Queue never stalls a fill
        fill_data  = m_r_data;
        hit_ready  = s_r_ready;

        if (hit_valid) begin
            // Hit wins the slave channel, memory beats wait
            s_r_valid = 1'b1;
            s_r_data  = hit_data;
            s_r_id    = hit_id;
            s_r_last  = 1'b1;
            m_r_ready = pf_beat;
        end else begin
            s_r_valid = m_r_valid && !pf_beat;
            s_r_data  = m_r_data;
            s_r_id    = m_r_id;
            s_r_last  = m_r_last;
            m_r_ready = pf_beat || s_r_ready;
        end
    end

    a_no_pf_id_out: assert property (@(posedge clk) disable iff (!rst_n)
        s_r_valid |-> s_r_id != PF_ID)
        else $error("prefetch beat leaked to the master");

    // Controller must hold a stalled hit response
    a_hit_hold: assert property (@(posedge clk) disable iff (!rst_n)
        hit_valid && !s_r_ready |=> hit_valid && $stable(hit_data) && $stable(hit_id))
        else $error("hit response changed under back-pressure");

endmodule

`default_nettype wire

//--- source/prefetcher_top.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Read prefetcher top level
// Steering, stream control and block queue
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`default_nettype none

module prefetcher_top (
    input  wire                clk,
    input  wire                rst_n,
    input  wire                en,
    input  wire pf_pkg::addr_t bar,
    input  wire pf_pkg::addr_t limit,
    // Slave AR
    input  wire                s_ar_valid,
    output logic               s_ar_ready,
    input  wire pf_pkg::addr_t s_ar_addr,
    input  wire pf_pkg::id_t   s_ar_id,
    input  wire pf_pkg::len_t  s_ar_len,
    // Master AR
    output logic               m_ar_valid,
    input  wire                m_ar_ready,
    output pf_pkg::addr_t      m_ar_addr,
    output pf_pkg::id_t        m_ar_id,
    output pf_pkg::len_t       m_ar_len,
    // Master R
    input  wire                m_r_valid,
    output logic               m_r_ready,
    input  wire pf_pkg::data_t m_r_data,
    input  wire pf_pkg::id_t   m_r_id,
    input  wire                m_r_last,
    // Slave R
    output logic               s_r_valid,
    input  wire                s_r_ready,
    output pf_pkg::data_t      s_r_data,
    output pf_pkg::id_t        s_r_id,
    output logic               s_r_last,
    // AW, address only
    input  wire                s_aw_valid,
    output logic               s_aw_ready,
    input  wire pf_pkg::addr_t s_aw_addr,
    input  wire pf_pkg::id_t   s_aw_id,
    output logic               m_aw_valid,
    input  wire                m_aw_ready
);
    import pf_pkg::*;

    // Steering to controller
    logic  ctrl_req_valid;
    logic  ctrl_req_ready;
    logic  ctrl_ar_valid;
    logic  ctrl_ar_ready;
    addr_t ctrl_ar_addr;
    id_t   ctrl_ar_id;
    len_t  ctrl_ar_len;
    logic  flush;

    // Hit response path
    logic  hit_valid;
    logic  hit_ready;
    data_t hit_data;
    id_t   hit_id;

    // Queue commands and status
    logic  push;
    addr_t push_addr;
    logic  pop;
    logic  clear;
    logic  head_valid;
    logic  head_filled;
    addr_t head_tag;
    data_t head_data;
    addr_t tail_next;
    cnt_t  count;
    logic  fill_valid;
    data_t fill_data;

    req_steer u_req_steer (.*);

    stream_ctrl u_stream_ctrl (.*);

    block_queue u_block_queue (.*);

    resp_steer u_resp_steer (.*);

endmodule

`default_nettype wire

//--- tests/axi_mem_model.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// In-order AXI read memory model
// Pattern data after random gaps, random AR stalls
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`default_nettype none

module axi_mem_model (
    input  wire                clk,
    input  wire                rst_n,
    input  wire                ar_valid,
    output logic               ar_ready,
    input  wire pf_pkg::addr_t ar_addr,
    input  wire pf_pkg::id_t   ar_id,
    input  wire pf_pkg::len_t  ar_len,
    output logic               r_valid,
    input  wire                r_ready,
    output pf_pkg::data_t      r_data,
    output pf_pkg::id_t        r_id,
    output logic               r_last
);
    import pf_pkg::*;

    addr_t       req_addr [$];
    id_t         req_id [$];
    len_t        req_len [$];
    addr_t       beat_addr;
    len_t        beats_left;                 // Beats still to send after the current one
    int unsigned gap;

    // Address in the upper half, its inverse in the lower half
    function automatic data_t mem_word(input addr_t a);
        return {a, ~a};
    endfunction

    always @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            ar_ready   <= 1'b0;
            r_valid    <= 1'b0;
            r_data     <= '0;
            r_id       <= '0;
            r_last     <= 1'b0;
            beat_addr  <= '0;
            beats_left <= '0;
            gap        <= 0;
            req_addr.delete();
            req_id.delete();
            req_len.delete();
        end else begin
            ar_ready <= ($urandom % 4) != 0;     // Random AR stalls
            if (ar_valid && ar_ready) begin
                req_addr.push_back(ar_addr);
                req_id.push_back(ar_id);
                req_len.push_back(ar_len);
            end
            if (r_valid && r_ready) begin
                if (r_last) begin
                    r_valid <= 1'b0;
                    gap     <= $urandom % 4;
                end else begin
                    beat_addr  <= beat_addr + addr_t'(BLOCK_BYTES);
                    beats_left <= beats_left - 1'b1;
                    r_data     <= mem_word(beat_addr + addr_t'(BLOCK_BYTES));
                    r_last     <= (beats_left == len_t'(1));
                end
            end else if (!r_valid && req_addr.size() != 0) begin
                if (gap != 0) begin
                    gap <= gap - 1;
                end else begin
                    // Start the oldest request
                    r_valid    <= 1'b1;
                    r_data     <= mem_word(req_addr[0]);
                    r_id       <= req_id[0];
                    r_last     <= (req_len[0] == '0);
                    beat_addr  <= req_addr[0];
                    beats_left <= req_len[0];
                    void'(req_addr.pop_front());
                    void'(req_id.pop_front());
                    void'(req_len.pop_front());
                end
            end
        end
    end

endmodule

`default_nettype wire

//--- tests/prefetcher_tb.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Read prefetcher testbench
// Table driven reads and writes with stream checks
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`default_nettype none

module prefetcher_tb;
    import pf_pkg::*;

    localparam int NUM_ROWS   = 18;
    localparam int WAIT_LIMIT = 200;

    typedef struct packed {
        logic  wr;
        addr_t addr;
        id_t   id;
        len_t  len;
        logic  en;
        logic  expect_demand;
    } row_t;

    // wr, addr, id, len, en, expect_demand
    localparam row_t ROWS [NUM_ROWS] = '{
        '{1'b0, 32'h2000, 4'd1,  8'd0, 1'b1, 1'b1},   // Outside the window
        '{1'b0, 32'h1000, 4'd2,  8'd3, 1'b1, 1'b1},   // Multi-beat bypass
        '{1'b0, 32'h1000, 4'd3,  8'd0, 1'b0, 1'b1},   // Prefetcher disabled
        '{1'b0, 32'h1000, 4'd3,  8'd0, 1'b1, 1'b1},   // Stream start
        '{1'b0, 32'h1008, 4'd4,  8'd0, 1'b1, 1'b0},
        '{1'b0, 32'h1010, 4'd5,  8'd0, 1'b1, 1'b0},
        '{1'b0, 32'h1018, 4'd6,  8'd0, 1'b1, 1'b0},
        '{1'b0, 32'h1020, 4'd7,  8'd0, 1'b1, 1'b0},
        '{1'b0, 32'h1028, 4'd8,  8'd0, 1'b1, 1'b0},   // Next block past limit
        '{1'b0, 32'h1008, 4'd9,  8'd0, 1'b1, 1'b1},   // Jump back, restart
        '{1'b1, 32'h1018, 4'd2,  8'd0, 1'b1, 1'b0},   // Flushing write
        '{1'b0, 32'h1010, 4'd10, 8'd0, 1'b1, 1'b1},
        '{1'b0, 32'h1018, 4'd11, 8'd0, 1'b1, 1'b0},
        '{1'b1, 32'h3000, 4'd3,  8'd0, 1'b1, 1'b0},   // Write outside, no flush
        '{1'b0, 32'h1020, 4'd12, 8'd0, 1'b1, 1'b0},
        '{1'b0, 32'h1038, 4'd13, 8'd0, 1'b1, 1'b1},   // Restart clipped to one block
        '{1'b0, 32'h1040, 4'd14, 8'd0, 1'b1, 1'b0},
        '{1'b0, 32'h1040, 4'd1,  8'd0, 1'b1, 1'b1}    // Empty queue at limit
    };

    logic  clk, rst_n, en;
    addr_t bar, limit;
    logic  s_ar_valid, s_ar_ready, m_ar_valid, m_ar_ready;
    addr_t s_ar_addr, m_ar_addr, s_aw_addr;
    id_t   s_ar_id, m_ar_id, m_r_id, s_r_id, s_aw_id;
    len_t  s_ar_len, m_ar_len;
    logic  m_r_valid, m_r_ready, m_r_last, s_r_valid, s_r_ready, s_r_last;
    data_t m_r_data, s_r_data;
    logic  s_aw_valid, s_aw_ready, m_aw_valid, m_aw_ready;

    addr_t exp_ar_addr [$];
    id_t   exp_ar_id [$];
    len_t  exp_ar_len [$];
    addr_t got_ar_addr [$];
    id_t   got_ar_id [$];
    len_t  got_ar_len [$];
    data_t exp_r_data [$];
    id_t   exp_r_id [$];
    logic  exp_r_last [$];
    data_t got_r_data [$];
    id_t   got_r_id [$];
    logic  got_r_last [$];
    addr_t stream_tags [$];                      // Blocks the DUT should hold
    addr_t stream_next;
    int    ar_checked;
    int    r_checked;

    prefetcher_top UUT (.*);

    axi_mem_model u_mem (
        .clk(clk), .rst_n(rst_n),
        .ar_valid(m_ar_valid), .ar_ready(m_ar_ready), .ar_addr(m_ar_addr),
        .ar_id(m_ar_id), .ar_len(m_ar_len),
        .r_valid(m_r_valid), .r_ready(m_r_ready), .r_data(m_r_data),
        .r_id(m_r_id), .r_last(m_r_last)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // Random back-pressure on slave R and AW
    always @(posedge clk) begin
        s_r_ready  <= ($urandom % 4) != 0;
        m_aw_ready <= ($urandom % 2) != 0;
    end

    always @(posedge clk) begin
        if (rst_n && m_ar_valid && m_ar_ready) begin
            got_ar_addr.push_back(m_ar_addr);
            got_ar_id.push_back(m_ar_id);
            got_ar_len.push_back(m_ar_len);
        end
        if (rst_n && s_r_valid && s_r_ready) begin
            got_r_data.push_back(s_r_data);
            got_r_id.push_back(s_r_id);
            got_r_last.push_back(s_r_last);
        end
    end

    function automatic data_t block_pattern(input addr_t a);
        return {a, ~a};
    endfunction

    task automatic fail_run(input string msg);
        $display("%s", msg);
        $display("Simulation FAILED");
        $fatal(1, "stopping on first error");
    endtask

    task automatic check_addr(input string name, input addr_t exp, input addr_t act);
        if (act !== exp)
            fail_run($sformatf("** Error %s: expected %h, actual %h", name, exp, act));
    endtask

    task automatic check_id(input string name, input id_t exp, input id_t act);
        if (act !== exp)
            fail_run($sformatf("** Error %s: expected %h, actual %h", name, exp, act));
    endtask

    task automatic check_len(input string name, input len_t exp, input len_t act);
        if (act !== exp)
            fail_run($sformatf("** Error %s: expected %h, actual %h", name, exp, act));
    endtask

    task automatic check_data(input string name, input data_t exp, input data_t act);
        if (act !== exp)
            fail_run($sformatf("** Error %s: expected %h, actual %h", name, exp, act));
    endtask

    task automatic check_flag(input string name, input logic exp, input logic act);
        if (act !== exp)
            fail_run($sformatf("** Error %s: expected %b, actual %b", name, exp, act));
    endtask

    task automatic expect_ar(input addr_t a, input id_t id, input len_t len);
        exp_ar_addr.push_back(a);
        exp_ar_id.push_back(id);
        exp_ar_len.push_back(len);
    endtask

    // Stream top-up: next block after the last one held, never past limit
    task automatic expect_prefetches();
        addr_t a;
        while (stream_tags.size() < QUEUE_DEPTH) begin
            a = (stream_tags.size() != 0) ? stream_tags[$] + addr_t'(BLOCK_BYTES) : stream_next;
            if (a > limit)
                break;
            expect_ar(a, PF_ID, '0);
            stream_tags.push_back(a);
            stream_next = a + addr_t'(BLOCK_BYTES);
        end
    endtask

    task automatic wait_results(input int r);
        int n;
        n = 0;
        while (got_ar_addr.size() < exp_ar_addr.size() ||
               got_r_data.size() < exp_r_data.size()) begin
            if (n == WAIT_LIMIT)
                fail_run($sformatf("Row %0d timed out waiting for AR requests or R beats", r));
            n++;
            @(posedge clk);
        end
    endtask

    task automatic compare_results(input int r);
        string tag;
        while (ar_checked < exp_ar_addr.size()) begin
            tag = $sformatf("row %0d AR %0d", r, ar_checked);
            check_addr({tag, " addr"}, exp_ar_addr[ar_checked], got_ar_addr[ar_checked]);
            check_id({tag, " id"}, exp_ar_id[ar_checked], got_ar_id[ar_checked]);
            check_len({tag, " len"}, exp_ar_len[ar_checked], got_ar_len[ar_checked]);
            ar_checked++;
        end
        while (r_checked < exp_r_data.size()) begin
            tag = $sformatf("row %0d R %0d", r, r_checked);
            check_data({tag, " data"}, exp_r_data[r_checked], got_r_data[r_checked]);
            check_id({tag, " id"}, exp_r_id[r_checked], got_r_id[r_checked]);
            check_flag({tag, " last"}, exp_r_last[r_checked], got_r_last[r_checked]);
            r_checked++;
        end
    endtask

    task automatic run_read(input int r, input row_t row);
        int   n;
        int   i;
        logic window;
        window = row.en && (row.len == '0) && (row.addr >= bar) && (row.addr <= limit);
        if (!window || row.expect_demand)
            expect_ar(row.addr, row.id, row.len);
        if (window) begin
            if (row.expect_demand) begin
                stream_tags.delete();            // Miss restarts the stream
                stream_next = row.addr + addr_t'(BLOCK_BYTES);
            end else begin
                void'(stream_tags.pop_front());
            end
            expect_prefetches();
        end
        for (i = 0; i <= int'(row.len); i++) begin
            exp_r_data.push_back(block_pattern(row.addr + addr_t'(i * BLOCK_BYTES)));
            exp_r_id.push_back(row.id);
            exp_r_last.push_back(i == int'(row.len));
        end
        @(posedge clk);
        en         <= row.en;
        s_ar_valid <= 1'b1;
        s_ar_addr  <= row.addr;
        s_ar_id    <= row.id;
        s_ar_len   <= row.len;
        n = 0;
        @(posedge clk);
        while (!s_ar_ready) begin
            if (n == WAIT_LIMIT)
                fail_run($sformatf("Row %0d read request was never accepted", r));
            n++;
            @(posedge clk);
        end
        s_ar_valid <= 1'b0;
        wait_results(r);
        compare_results(r);
    endtask

    task automatic run_write(input int r, input row_t row);
        int n;
        @(posedge clk);
        en         <= row.en;
        s_aw_valid <= 1'b1;
        s_aw_addr  <= row.addr;
        s_aw_id    <= row.id;
        n = 0;
        @(posedge clk);
        while (!s_aw_ready) begin
            if (n == WAIT_LIMIT)
                fail_run($sformatf("Row %0d write address was never accepted", r));
            n++;
            @(posedge clk);
        end
        if (!m_aw_valid)
            fail_run($sformatf("Row %0d write address did not reach the master AW", r));
        s_aw_valid <= 1'b0;
        if (row.en && row.addr >= bar && row.addr <= limit)
            stream_tags.delete();                // Write into the window flushes the stream
    endtask

    initial begin
        void'($urandom(32'h23f6));
        rst_n       = 1'b0;
        en          = 1'b0;
        bar         = 32'h0000_1000;
        limit       = 32'h0000_1040;
        s_ar_valid  = 1'b0;
        s_ar_addr   = '0;
        s_ar_id     = '0;
        s_ar_len    = '0;
        s_r_ready   = 1'b0;
        s_aw_valid  = 1'b0;
        s_aw_addr   = '0;
        s_aw_id     = '0;
        m_aw_ready  = 1'b0;
        stream_next = '0;
        ar_checked  = 0;
        r_checked   = 0;
        repeat (8) @(posedge clk);
        rst_n <= 1'b1;

        // Quiet bus after reset
        repeat (4) begin
            @(posedge clk);
            if (m_ar_valid || s_r_valid)
                fail_run("Master AR or slave R went valid on an idle bus after reset");
        end

        for (int r = 0; r < NUM_ROWS; r++) begin
            if (ROWS[r].wr)
                run_write(r, ROWS[r]);
            else
                run_read(r, ROWS[r]);
        end

        repeat (20) @(posedge clk);              // Let stray traffic show up
        if (got_ar_addr.size() != exp_ar_addr.size() ||
            got_r_data.size() != exp_r_data.size()) begin
            fail_run("Extra AR requests or R beats appeared after the last row");
        end else begin
            $display("Simulation PASSED");
            $finish;
        end
    end

endmodule

`default_nettype wire

//--- sim.f
common/pf_pkg.sv
source/req_steer.sv
prefetch/stream_ctrl.sv
prefetch/block_queue.sv
source/resp_steer.sv
source/prefetcher_top.sv
tests/axi_mem_model.sv
tests/prefetcher_tb.sv
